// ==== pktout_mux_top.f ====
+incdir+test
verilog/jbus_pkg.sv
verilog/rdq_format.sv
verilog/pio_format.sv
verilog/ack_format.sv
verilog/cycle_mux.sv
verilog/bus_drive.sv
verilog/pktout_mux_top.sv
test/tb_pktout_mux.sv

// ==== test/pktout_model.svh ====
// ~~~~~~~~~~~~~~~~~~~~
// Reference model of the JBus output formatter
//   Expected ad-type byte and word per beat
//   Lane parity and error injection
//   Per-queue ue history
// ~~~~~~~~~~~~~~~~~~~~

`ifndef PKTOUT_MODEL_SVH
`define PKTOUT_MODEL_SVH

// ue flag of each read queue during the previous cycle
logic model_ue_prev [4];

task automatic model_clear_history();
  for (int q = 0; q < 4; q++) begin
    model_ue_prev[q] = 1'b0;
  end
endtask

task automatic model_record_ue(input int q, input logic ue);
  model_ue_prev[q] = ue;
endtask

function automatic logic [7:0] model_rdq_adtype(input logic [3:0] beat, input logic [5:0] jid,
                                                input logic install, input logic ue,
                                                input logic prev);
  logic [7:0] t;
  t = 8'h00;
  case (beat)
    RD16:   t = {2'b10, jid};
    RD64_0: t = {2'b01, jid};
    RDER:   t = {2'b00, jid};
    RD64_1: begin
      t[6]   = prev;
      t[4]   = ue;
      t[2:0] = install ? 3'd1 : 3'd0;
    end
    RD64_2, RD64_3: t[4] = ue;
    default: t = 8'h00;
  endcase
  return t;
endfunction

function automatic logic [127:0] model_rdq_ad(input logic [3:0] beat, input logic [127:0] data,
                                              input logic unmapped);
  logic [127:0] w;
  w = data;
  // Unmapped reports 2, any other read error 1
  if (beat == RDER) begin
    w[2:0] = unmapped ? 3'd2 : 3'd1;
  end
  return w;
endfunction

function automatic logic [7:0] model_pio_adtype(input logic [3:0] beat, input logic ue,
                                                input logic [5:0] ujid);
  logic [7:0] t;
  t = 8'h00;
  if (beat == NCRD) begin
    t = {2'b11, ujid};
  end else if (beat == NCWR_0) begin
    t[7:6] = 2'b11;
  end else if (beat == NCWR_1) begin
    t[4] = ue;
  end
  return t;
endfunction

function automatic logic [127:0] model_pio_ad(input logic [3:0] beat, input logic [15:0] be,
                                              input logic [63:0] pad);
  logic [63:0] h;
  if (beat == NCWR_1) begin
    return {pad, pad};
  end
  h[63:48] = be;
  h[47:43] = (beat == NCRD) ? 5'h00 : 5'h01;
  h[42:0]  = pad[42:0];
  return {h, h};
endfunction

function automatic logic [127:0] model_ack_ad(input logic [3:0] beat, input logic [4:0] agnt,
                                              input logic [4:0] cpu);
  logic [63:0] h;
  h = 64'h0;
  h[47:43] = (beat == INTNACK) ? 5'h19 : 5'h18;
  h[40:36] = agnt;
  h[35:31] = cpu;
  return {h, h};
endfunction

// Odd parity, lane 3 also counts the ad-type byte
function automatic logic [3:0] model_parity(input logic [7:0] adtype, input logic [127:0] ad);
  logic [3:0] p;
  int ones;
  for (int i = 0; i < 4; i++) begin
    ones = 0;
    for (int b = 0; b < 32; b++) begin
      ones += ad[32*i + b];
    end
    if (i == 3) begin
      for (int b = 0; b < 8; b++) begin
        ones += adtype[b];
      end
    end
    p[i] = (ones % 2 == 0);
  end
  return p;
endfunction

function automatic logic [127:0] model_inject(input logic [127:0] ad, input logic [3:0] inj);
  logic [127:0] w;
  w = ad;
  for (int i = 0; i < 4; i++) begin
    w[32*i] = ad[32*i] ^ inj[i];
  end
  return w;
endfunction

`endif

// ==== test/tb_pktout_mux.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Testbench of the JBus output formatter
//   Clock, reset and seeded random stimulus
//   Model compare, watchdog and summary
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module tb_pktout_mux
  import jbus_pkg::*;
;

  localparam int N_RDQ        = 4;
  localparam int RESET_CYCLES = 16;
  localparam int N_CYCLES     = 2000;
  localparam int TIMEOUT_NS   = (RESET_CYCLES + N_CYCLES) * 10 + 500;

  logic       clk;
  logic       arst_n;
  queue_sel_e sel_queue;
  beat_sel_e  sel_beat;
  logic       rdq_install_state [N_RDQ];
  logic       rdq_unmapped_error [N_RDQ];
  jid_t       rdq_jid [N_RDQ];
  ad_t        rdq_data [N_RDQ];
  logic       rdq_ue_err [N_RDQ];
  logic       pio_ue;
  be_t        pio_be;
  half_t      pio_ad;
  mondo_id_t  mondo_agnt_id;
  mondo_id_t  mondo_cpu_id;
  jid_t       unused_jid;
  lane_bits_t inj_err;
  adtype_t    j_adtype;
  ad_t        j_ad;
  lane_bits_t j_adp;

  int errors;
  int checks;

  `include "pktout_model.svh"

  pktout_mux_top #(
    .N_RDQ (N_RDQ)
  ) DUT (
    .clk                (clk),
    .arst_n             (arst_n),
    .sel_queue          (sel_queue),
    .sel_beat           (sel_beat),
    .rdq_install_state  (rdq_install_state),
    .rdq_unmapped_error (rdq_unmapped_error),
    .rdq_jid            (rdq_jid),
    .rdq_data           (rdq_data),
    .rdq_ue_err         (rdq_ue_err),
    .pio_ue             (pio_ue),
    .pio_be             (pio_be),
    .pio_ad             (pio_ad),
    .mondo_agnt_id      (mondo_agnt_id),
    .mondo_cpu_id       (mondo_cpu_id),
    .unused_jid         (unused_jid),
    .inj_err            (inj_err),
    .j_adtype           (j_adtype),
    .j_ad               (j_ad),
    .j_adp              (j_adp)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_value(input string what, input logic [127:0] got,
                             input logic [127:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // Legal queue and beat pair plus fresh data on every input
  task automatic drive_random_cycle(input bit first_cycle);
    int unsigned q;
    int unsigned b;
    int unsigned r;
    q = $urandom_range(7, 0);
    if (first_cycle) begin
      q = $urandom_range(3, 0);
      b = RD64_1;
    end else if (q < 4) begin
      b = $urandom_range(6, 0);
    end else if (q == 4) begin
      r = $urandom_range(3, 0);
      b = (r == 0) ? 0 : r + 6;
    end else if (q == 5) begin
      r = $urandom_range(2, 0);
      b = (r == 0) ? 0 : r + 9;
    end else begin
      b = 0;
    end
    sel_queue <= queue_sel_e'(q[2:0]);
    sel_beat  <= beat_sel_e'(b[3:0]);
    for (int i = 0; i < N_RDQ; i++) begin
      rdq_install_state[i]  <= 1'($urandom);
      rdq_unmapped_error[i] <= 1'($urandom);
      rdq_jid[i]            <= 6'($urandom);
      rdq_data[i]           <= {$urandom, $urandom, $urandom, $urandom};
      rdq_ue_err[i]         <= 1'($urandom);
    end
    pio_ue        <= 1'($urandom);
    pio_be        <= 16'($urandom);
    pio_ad        <= {$urandom, $urandom};
    mondo_agnt_id <= 5'($urandom);
    mondo_cpu_id  <= 5'($urandom);
    unused_jid    <= 6'($urandom);
    inj_err       <= 4'($urandom);
  endtask

  task automatic check_cycle();
    logic [7:0]   exp_adtype;
    logic [127:0] exp_ad;
    logic [127:0] clean_ad;
    logic [3:0]   b;
    int           q;
    string        tag;
    q   = int'(sel_queue);
    b   = sel_beat;
    tag = $sformatf("queue %0d beat %0d", q, b);
    if (b == IDLE) begin
      exp_adtype = 8'hff;
      exp_ad     = '1;
    end else if (q < N_RDQ) begin
      exp_adtype = model_rdq_adtype(b, rdq_jid[q], rdq_install_state[q], rdq_ue_err[q],
                                    model_ue_prev[q]);
      exp_ad     = model_rdq_ad(b, rdq_data[q], rdq_unmapped_error[q]);
    end else if (q == 4) begin
      exp_adtype = model_pio_adtype(b, pio_ue, unused_jid);
      exp_ad     = model_pio_ad(b, pio_be, pio_ad);
    end else begin
      exp_adtype = 8'hc0;
      exp_ad     = model_ack_ad(b, mondo_agnt_id, mondo_cpu_id);
    end
    check_value({tag, " j_adtype"}, j_adtype, exp_adtype);
    check_value({tag, " j_ad"}, j_ad, model_inject(exp_ad, inj_err));
    check_value({tag, " j_adp"}, j_adp, model_parity(exp_adtype, exp_ad));
    // PIO and interrupt cycles repeat one half
    if (b >= NCRD) begin
      clean_ad = model_inject(j_ad, inj_err);
      check_value({tag, " halves"}, clean_ad[127:64], clean_ad[63:0]);
    end
  endtask

  initial begin
    void'($urandom(32'h39cb));
    errors    = 0;
    checks    = 0;
    arst_n    = 1'b0;
    sel_queue = SCT0;
    sel_beat  = IDLE;
    // ue held high in reset, the history must still come out as 0
    for (int i = 0; i < N_RDQ; i++) begin
      rdq_install_state[i]  = 1'b0;
      rdq_unmapped_error[i] = 1'b0;
      rdq_jid[i]            = '0;
      rdq_data[i]           = '0;
      rdq_ue_err[i]         = 1'b1;
    end
    pio_ue        = 1'b0;
    pio_be        = '0;
    pio_ad        = '0;
    mondo_agnt_id = '0;
    mondo_cpu_id  = '0;
    unused_jid    = '0;
    inj_err       = '0;
    model_clear_history();
    repeat (RESET_CYCLES - 1) @(posedge clk);
    for (int n = 0; n < N_CYCLES; n++) begin
      @(posedge clk);
      // First cycle runs before any edge out of reset
      if (n == 0) begin
        arst_n <= 1'b1;
      end
      drive_random_cycle(n == 0);
      @(negedge clk);
      check_cycle();
      // Every queue register samples its ue input at each edge
      for (int q = 0; q < N_RDQ; q++) begin
        model_record_ue(q, rdq_ue_err[q]);
      end
    end
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the test did not complete within %0d ns", TIMEOUT_NS);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== verilog/ack_format.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Interrupt ack formatter
//   INTACK and INTNACK address cycles
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module ack_format
  import jbus_pkg::*;
(
  input  beat_sel_e sel_beat,
  input  mondo_id_t mondo_agnt_id,
  input  mondo_id_t mondo_cpu_id,
  output adtype_t   adtype,
  output ad_t       ad,
  output logic      beat_ok
);

  logic [4:0] trans;
  half_t      int_half;

  assign beat_ok = (sel_beat == INTACK) || (sel_beat == INTNACK);
  assign trans   = (sel_beat == INTNACK) ? TRANS_INTNACK : TRANS_INTACK;

  // Target agent then source cpu, low 31 bits unused
  assign int_half = {16'h0000, trans, 2'h0, mondo_agnt_id, mondo_cpu_id, 31'h0};

  assign adtype = {2'h3, 6'h00};
  assign ad     = {int_half, int_half};

endmodule

// ==== verilog/bus_drive.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Bus driver
//   Odd parity per 32-bit lane
//   Error injection on bits 96, 64, 32, 0
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module bus_drive
  import jbus_pkg::*;
(
  input  adtype_t    mux_adtype,
  input  ad_t        mux_ad,
  input  lane_bits_t inj_err,
  output adtype_t    j_adtype,
  output ad_t        j_ad,
  output lane_bits_t j_adp
);

  lane_bits_t lane_xor;

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      lane_xor[i] = ^mux_ad[32*i +: 32];
    end
  end

  // Lane 3 parity also covers the ad-type byte
  assign j_adp = ~(lane_xor ^ {^mux_adtype, 3'b000});

  // Flip the low bit of each lane, parity keeps the clean value
  always_comb begin
    j_ad = mux_ad;
    for (int i = 0; i < 4; i++) begin
      j_ad[32*i] = mux_ad[32*i] ^ inj_err[i];
    end
  end

  assign j_adtype = mux_adtype;

endmodule

// ==== verilog/cycle_mux.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Bus cycle multiplexer
//   Idle cycle or selected source
//   Illegal select check
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module cycle_mux
  import jbus_pkg::*;
#(
  parameter int N_RDQ = 4
) (
  input  logic       clk,
  input  queue_sel_e sel_queue,
  input  beat_sel_e  sel_beat,
  input  adtype_t    rdq_adtype [N_RDQ],
  input  ad_t        rdq_ad [N_RDQ],
  input  logic       rdq_beat_ok [N_RDQ],
  input  adtype_t    pio_adtype,
  input  ad_t        pio_ad,
  input  logic       pio_beat_ok,
  input  adtype_t    ack_adtype,
  input  ad_t        ack_ad,
  input  logic       ack_beat_ok,
  output adtype_t    mux_adtype,
  output ad_t        mux_ad
);

  adtype_t src_adtype;
  ad_t     src_ad;
  logic    src_ok;

  // Source named by the queue select
  always_comb begin
    src_adtype = IDLE_ADTYPE;
    src_ad     = '1;
    src_ok     = 1'b0;
    // Read queues above N_RDQ-1 do not exist
    for (int q = 0; q < N_RDQ; q++) begin
      if (int'(sel_queue) == q) begin
        src_adtype = rdq_adtype[q];
        src_ad     = rdq_ad[q];
        src_ok     = rdq_beat_ok[q];
      end
    end
    case (sel_queue)
      PIORQQ: begin
        src_adtype = pio_adtype;
        src_ad     = pio_ad;
        src_ok     = pio_beat_ok;
      end
      PIOACKQ: begin
        src_adtype = ack_adtype;
        src_ad     = ack_ad;
        src_ok     = ack_beat_ok;
      end
      default: ;
    endcase
  end

  // Idle beats leave the bus undriven
  always_comb begin
    if (sel_beat == IDLE) begin
      mux_adtype = IDLE_ADTYPE;
      mux_ad     = '1;
    end else begin
      mux_adtype = src_adtype;
      mux_ad     = src_ad;
    end
  end

  // Missing queue, or a beat the selected formatter does not own
  legal_select_a: assert property (
    @(posedge clk)
    !$isunknown({sel_queue, sel_beat}) && (sel_beat != IDLE) |-> src_ok
  ) else $error("illegal select, queue %0d beat %0d", sel_queue, sel_beat);

endmodule

// ==== verilog/jbus_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// JBus output formatter package
//   Bus field types
//   Queue and beat select codes
//   Transaction, install and error encodings
// ~~~~~~~~~~~~~~~~~~~~

package jbus_pkg;

  // Bus field types
  typedef logic [7:0]   adtype_t;
  typedef logic [127:0] ad_t;
  typedef logic [63:0]  half_t;

  // Target agent id in [5:2], transaction id in [1:0]
  typedef logic [5:0]   jid_t;

  typedef logic [4:0]   mondo_id_t;
  typedef logic [15:0]  be_t;

  // One bit per 32-bit lane of the ad word
  typedef logic [3:0]   lane_bits_t;

  // Queue select, codes 6 and 7 are never legal
  typedef enum logic [2:0] {
    SCT0    = 3'd0,
    SCT1    = 3'd1,
    SCT2    = 3'd2,
    SCT3    = 3'd3,
    PIORQQ  = 3'd4,
    PIOACKQ = 3'd5
  } queue_sel_e;

  // Beat select within the current transaction
  typedef enum logic [3:0] {
    IDLE    = 4'd0,
    RD16    = 4'd1,
    RD64_0  = 4'd2,
    RD64_1  = 4'd3,
    RD64_2  = 4'd4,
    RD64_3  = 4'd5,
    RDER    = 4'd6,
    NCRD    = 4'd7,
    NCWR_0  = 4'd8,
    NCWR_1  = 4'd9,
    INTACK  = 4'd10,
    INTNACK = 4'd11
  } beat_sel_e;

  // Transaction codes of address cycles
  localparam logic [4:0] TRANS_NCRD    = 5'h00;
  localparam logic [4:0] TRANS_NCWR    = 5'h01;
  localparam logic [4:0] TRANS_INTACK  = 5'h18;
  localparam logic [4:0] TRANS_INTNACK = 5'h19;

  // Install state reported on RD64 beat 1
  localparam logic [2:0] INSTALL_INVALID = 3'd0;
  localparam logic [2:0] INSTALL_SHARED  = 3'd1;

  // Error code in the low bits of an RDER word
  localparam logic [2:0] RDER_BUS_ERROR = 3'd1;
  localparam logic [2:0] RDER_UNMAPPED  = 3'd2;

  // Undriven bus reads as all ones
  localparam adtype_t IDLE_ADTYPE = 8'hff;

endpackage

// ==== verilog/pio_format.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// PIO request formatter
//   NCRD address cycle
//   NCWR address and data cycles
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module pio_format
  import jbus_pkg::*;
(
  input  beat_sel_e sel_beat,
  input  logic      pio_ue,
  input  be_t       pio_be,
  input  half_t     pio_ad,
  input  jid_t      unused_jid,
  output adtype_t   adtype,
  output ad_t       ad,
  output logic      beat_ok
);

  logic [4:0] trans;
  half_t      addr_half;

  assign trans     = (sel_beat == NCRD) ? TRANS_NCRD : TRANS_NCWR;
  assign addr_half = {pio_be, trans, pio_ad[42:0]};

  always_comb begin
    adtype  = '0;
    ad      = {addr_half, addr_half};
    beat_ok = 1'b1;
    case (sel_beat)
      NCRD:   adtype = {2'h3, unused_jid};
      NCWR_0: adtype = {2'h3, 6'h00};
      // Write data beat, same 8 bytes on both halves
      NCWR_1: begin
        adtype = {3'h0, pio_ue, 4'h0};
        ad     = {pio_ad, pio_ad};
      end
      default: beat_ok = 1'b0;
    endcase
  end

endmodule

// ==== verilog/pktout_mux_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// JBus packet output formatter, top level
//   Read queue, PIO and interrupt ack formatters
//   Cycle mux and bus driver
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module pktout_mux_top
  import jbus_pkg::*;
#(
  parameter int N_RDQ = 4
) (
  input  logic       clk,
  input  logic       arst_n,
  input  queue_sel_e sel_queue,
  input  beat_sel_e  sel_beat,
  input  logic       rdq_install_state [N_RDQ],
  input  logic       rdq_unmapped_error [N_RDQ],
  input  jid_t       rdq_jid [N_RDQ],
  input  ad_t        rdq_data [N_RDQ],
  input  logic       rdq_ue_err [N_RDQ],
  input  logic       pio_ue,
  input  be_t        pio_be,
  input  half_t      pio_ad,
  input  mondo_id_t  mondo_agnt_id,
  input  mondo_id_t  mondo_cpu_id,
  input  jid_t       unused_jid,
  input  lane_bits_t inj_err,
  output adtype_t    j_adtype,
  output ad_t        j_ad,
  output lane_bits_t j_adp
);

  adtype_t rdq_adtype [N_RDQ];
  ad_t     rdq_ad [N_RDQ];
  logic    rdq_beat_ok [N_RDQ];

  adtype_t piorqq_adtype;
  ad_t     piorqq_ad;
  logic    piorqq_beat_ok;

  adtype_t pioackq_adtype;
  ad_t     pioackq_ad;
  logic    pioackq_beat_ok;

  adtype_t mux_adtype;
  ad_t     mux_ad;

  // One formatter per L2 read queue
  for (genvar g = 0; g < N_RDQ; g++) begin : g_rdq
    rdq_format u_rdq_format (
      .clk            (clk),
      .arst_n         (arst_n),
      .sel_beat       (sel_beat),
      .install_state  (rdq_install_state[g]),
      .unmapped_error (rdq_unmapped_error[g]),
      .jid            (rdq_jid[g]),
      .data           (rdq_data[g]),
      .ue_err         (rdq_ue_err[g]),
      .adtype         (rdq_adtype[g]),
      .ad             (rdq_ad[g]),
      .beat_ok        (rdq_beat_ok[g])
    );
  end

  pio_format u_pio_format (
    .sel_beat   (sel_beat),
    .pio_ue     (pio_ue),
    .pio_be     (pio_be),
    .pio_ad     (pio_ad),
    .unused_jid (unused_jid),
    .adtype     (piorqq_adtype),
    .ad         (piorqq_ad),
    .beat_ok    (piorqq_beat_ok)
  );

  ack_format u_ack_format (
    .sel_beat      (sel_beat),
    .mondo_agnt_id (mondo_agnt_id),
    .mondo_cpu_id  (mondo_cpu_id),
    .adtype        (pioackq_adtype),
    .ad            (pioackq_ad),
    .beat_ok       (pioackq_beat_ok)
  );

  cycle_mux #(
    .N_RDQ (N_RDQ)
  ) u_cycle_mux (
    .clk         (clk),
    .sel_queue   (sel_queue),
    .sel_beat    (sel_beat),
    .rdq_adtype  (rdq_adtype),
    .rdq_ad      (rdq_ad),
    .rdq_beat_ok (rdq_beat_ok),
    .pio_adtype  (piorqq_adtype),
    .pio_ad      (piorqq_ad),
    .pio_beat_ok (piorqq_beat_ok),
    .ack_adtype  (pioackq_adtype),
    .ack_ad      (pioackq_ad),
    .ack_beat_ok (pioackq_beat_ok),
    .mux_adtype  (mux_adtype),
    .mux_ad      (mux_ad)
  );

  bus_drive u_bus_drive (
    .mux_adtype (mux_adtype),
    .mux_ad     (mux_ad),
    .inj_err    (inj_err),
    .j_adtype   (j_adtype),
    .j_ad       (j_ad),
    .j_adp      (j_adp)
  );

endmodule

// ==== verilog/rdq_format.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Read-return queue formatter
//   RD16, RD64 beats 0..3 and RDER cycles
//   Previous-cycle ue error history
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module rdq_format
  import jbus_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  beat_sel_e sel_beat,
  input  logic      install_state,
  input  logic      unmapped_error,
  input  jid_t      jid,
  input  ad_t       data,
  input  logic      ue_err,
  output adtype_t   adtype,
  output ad_t       ad,
  output logic      beat_ok
);

  logic       ue_prev;
  logic [2:0] install_code;
  logic [2:0] rder_code;

  // ue flag as seen in the cycle before
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ue_prev <= 1'b0;
    end else begin
      ue_prev <= ue_err;
    end
  end

  assign install_code = install_state ? INSTALL_SHARED : INSTALL_INVALID;
  assign rder_code    = unmapped_error ? RDER_UNMAPPED : RDER_BUS_ERROR;

  always_comb begin
    adtype  = '0;
    ad      = data;
    beat_ok = 1'b1;
    case (sel_beat)
      RD16:   adtype = {2'h2, jid};
      RD64_0: adtype = {2'h1, jid};
      // Error flags ride in the ad-type byte of the second beat
      RD64_1: adtype = {1'b0, ue_prev, 1'b0, ue_err, 1'b0, install_code};
      RD64_2,
      RD64_3: adtype = {3'h0, ue_err, 4'h0};
      RDER: begin
        adtype = {2'h0, jid};
        ad     = {data[127:3], rder_code};
      end
      default: beat_ok = 1'b0;
    endcase
  end

  // History must be known once the queue is out of reset
  ue_hist_known_a: assert property (
    @(posedge clk) disable iff (!arst_n)
    !$isunknown(ue_prev)
  ) else $error("ue error history is unknown");

endmodule
